// File: sim/csr_file_testdata.txt
# All operands hex. W num mask value | R num expect | X ecode subcode pc vaddr | E
# H hw ipi | C cycles | I has_int | A ex_entry
R 0000 00000008
R 0042 ffffffff
I 0
W 0030 ffffffff 12345678
W 0030 0000ffff aaaabbbb
R 0030 1234bbbb
W 0031 ffffffff 0badf00d
W 0032 ffffffff 00000000
W 0032 ff00ff00 ffffffff
W 0033 ffffffff cafe0001
R 0031 0badf00d
R 0032 ff00ff00
R 0033 cafe0001
W 0006 ffffffff 11110000
W 0006 000000ff 222222ab
R 0006 111100ab
W 0004 ffffffff ffffffff
R 0004 00001bff
W 000c ffffffff 1c00ffff
R 000c 1c00ffc0
A 1c00ffc0
R 0099 00000000
R 0044 00000000
W 0000 00000007 00000007
R 0000 0000000f
X 08 000 1c000100 deadbeef
R 0001 00000007
R 0000 00000008
R 0006 1c000100
R 0005 00080000
R 0007 1c000100
E
R 0000 0000000f
X 09 000 1c000200 00001234
R 0007 00001234
R 0005 00090000
X 0b 005 1c000300 55555555
R 0007 00001234
R 0005 014b0000
R 0001 00000000
R 0006 1c000300
W 0004 ffffffff 00000000
H 05 1
C 1
R 0005 014b1014
I 0
W 0004 ffffffff 00000004
I 0
W 0000 00000004 00000004
I 1
W 0000 00000004 00000000
I 0
W 0000 00000004 00000004
I 1
X 0b 000 1c000400 00000000
I 0
E
W 0004 ffffffff 00001000
I 1
H 00 0
C 1
I 0
W 0041 ffffffff 00000011
C 5
R 0042 0000000b
R 0041 00000011
C 10
R 0042 ffffffff
R 0005 000b0800
W 0044 00000001 00000001
R 0005 000b0000
W 0004 ffffffff 00000800
W 0041 ffffffff 0000000b
C 9
R 0042 00000008
R 0005 000b0800
I 1
W 0000 00000004 00000000
I 0

// File: csr_file.f
+incdir+include
logic/csr_pkg.sv
logic/csr_mode_ctrl.sv
logic/csr_timer.sv
logic/csr_exc_info.sv
logic/csr_save_bank.sv
logic/csr_read_mux.sv
logic/csr_file.sv
sim/csr_file_tb.sv

// File: Makefile
TOP   := csr_file_tb
BUILD := obj_dir
LOG   := sim.log

SOURCES := csr_file.f $(wildcard include/*.svh logic/*.sv sim/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f csr_file.f --top-module $(TOP) -Mdir $(BUILD)

run: $(BUILD)/V$(TOP) sim/csr_file_testdata.txt
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f csr_file.f --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/csr_file_tb.sv
module csr_file_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    localparam int    CLK_HALF        = 2;
    localparam int    RESET_CYCLES    = 10;
    localparam int    CYCLES_PER_LINE = 50;
    localparam string DATA_FILE       = "sim/csr_file_testdata.txt";

    logic       clk;
    logic       reset;
    logic       csr_we;
    csr_num_t   csr_num;
    csr_word_t  csr_wmask;
    csr_word_t  csr_wvalue;
    csr_word_t  csr_rvalue;
    logic       wb_ex;
    ecode_t     wb_ecode;
    esubcode_t  wb_esubcode;
    csr_word_t  wb_pc;
    csr_word_t  wb_vaddr;
    logic       ertn_flush;
    logic [7:0] hw_int;
    logic       ipi_int;
    logic       has_int;
    csr_word_t  ex_entry;

    int         fd;
    int         line_count;
    bit         lines_counted;
    csr_word_t  op [4];

    csr_file dut (.*);

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input csr_word_t got, input csr_word_t expected);
        if (got !== expected) begin
            fail_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected));
        end
    endtask

    // Watchdog budget comes from the file length
    task automatic count_lines();
        int c;
        line_count = 0;
        c = $fgetc(fd);
        while (c != -1) begin
            if (c[7:0] == 8'h0a) begin
                line_count++;
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        fd = $fopen(DATA_FILE, "r");
        lines_counted = 1'b1;
    endtask

    // Skip blanks and comment lines up to the next command letter
    task automatic next_command(output int c);
        logic [7:0] ch;
        c = $fgetc(fd);
        ch = c[7:0];
        while (c != -1 && (ch == " " || ch == "\t" || ch == "\n" || ch == "\r" || ch == "#")) begin
            if (ch == "#") begin
                while (c != -1 && ch != "\n") begin
                    c = $fgetc(fd);
                    ch = c[7:0];
                end
            end else begin
                c = $fgetc(fd);
                ch = c[7:0];
            end
        end
    endtask

    task automatic read_operands(input int count);
        csr_word_t v;
        int        n;
        for (int i = 0; i < count; i++) begin
            n = $fscanf(fd, "%h", v);
            if (n != 1) begin
                fail_run("A line of the test data file is missing an operand");
            end
            op[i] = v;
        end
    endtask

    // One clock edge with all strobes dropped
    task automatic step_idle();
        @(posedge clk);
        csr_we     <= 1'b0;
        wb_ex      <= 1'b0;
        ertn_flush <= 1'b0;
    endtask

    initial begin
        wait (lines_counted);
        repeat (RESET_CYCLES + line_count * CYCLES_PER_LINE) @(posedge clk);
        fail_run("Watchdog expired before the test data file was finished");
    end

    initial begin
        int         c;
        logic [7:0] ch;
        reset       <= 1'b1;
        csr_we      <= 1'b0;
        csr_num     <= '0;
        csr_wmask   <= '0;
        csr_wvalue  <= '0;
        wb_ex       <= 1'b0;
        wb_ecode    <= '0;
        wb_esubcode <= '0;
        wb_pc       <= '0;
        wb_vaddr    <= '0;
        ertn_flush  <= 1'b0;
        hw_int      <= '0;
        ipi_int     <= 1'b0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            fail_run("Could not open the test data file sim/csr_file_testdata.txt");
        end
        count_lines();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        next_command(c);
        while (c != -1) begin
            ch = c[7:0];
            case (ch)
                "W": begin
                    read_operands(3);
                    step_idle();
                    csr_we     <= 1'b1;
                    csr_num    <= op[0][13:0];
                    csr_wmask  <= op[1];
                    csr_wvalue <= op[2];
                end
                "R": begin
                    read_operands(2);
                    step_idle();
                    csr_num <= op[0][13:0];
                    @(negedge clk);
                    check_value($sformatf("csr_rvalue (csr 0x%04h)", op[0][13:0]),
                                csr_rvalue, op[1]);
                end
                "X": begin
                    read_operands(4);
                    step_idle();
                    wb_ex       <= 1'b1;
                    wb_ecode    <= op[0][5:0];
                    wb_esubcode <= op[1][8:0];
                    wb_pc       <= op[2];
                    wb_vaddr    <= op[3];
                end
                "E": begin
                    step_idle();
                    ertn_flush <= 1'b1;
                end
                "H": begin
                    read_operands(2);
                    step_idle();
                    hw_int  <= op[0][7:0];
                    ipi_int <= op[1][0];
                end
                "C": begin
                    read_operands(1);
                    repeat (op[0]) step_idle();
                end
                "I": begin
                    read_operands(1);
                    step_idle();
                    @(negedge clk);
                    check_value("has_int", {31'b0, has_int}, op[0]);
                end
                "A": begin
                    read_operands(1);
                    step_idle();
                    @(negedge clk);
                    check_value("ex_entry", ex_entry, op[0]);
                end
                default: begin
                    fail_run($sformatf("Unknown command letter '%c' in the test data file", ch));
                end
            endcase
            next_command(c);
        end
        $fclose(fd);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: logic/csr_file.sv
module csr_file (
    input  logic                clk,
    input  logic                reset,
    input  logic                csr_we,
    input  csr_pkg::csr_num_t   csr_num,
    input  csr_pkg::csr_word_t  csr_wmask,
    input  csr_pkg::csr_word_t  csr_wvalue,
    output csr_pkg::csr_word_t  csr_rvalue,
    input  logic                wb_ex,
    input  csr_pkg::ecode_t     wb_ecode,
    input  csr_pkg::esubcode_t  wb_esubcode,
    input  csr_pkg::csr_word_t  wb_pc,
    input  csr_pkg::csr_word_t  wb_vaddr,
    input  logic                ertn_flush,
    input  logic [7:0]          hw_int,
    input  logic                ipi_int,
    output logic                has_int,
    output csr_pkg::csr_word_t  ex_entry
);
    import csr_pkg::*;

    plv_t        crmd_plv;
    logic        crmd_ie;
    plv_t        prmd_pplv;
    logic        prmd_pie;
    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    csr_word_t   tval;
    logic        timer_int;
    int_vec_t    ecfg_lie;
    int_vec_t    estat_is;
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    csr_word_t   era;
    csr_word_t   badv;
    logic [25:0] eentry_va;
    csr_word_t   save0;
    csr_word_t   save1;
    csr_word_t   save2;
    csr_word_t   save3;

    csr_mode_ctrl u_mode_ctrl (
        .clk(clk), .reset(reset),
        .csr_we(csr_we), .csr_num(csr_num), .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .wb_ex(wb_ex), .ertn_flush(ertn_flush),
        .crmd_plv(crmd_plv), .crmd_ie(crmd_ie), .prmd_pplv(prmd_pplv), .prmd_pie(prmd_pie)
    );

    csr_timer u_timer (
        .clk(clk), .reset(reset),
        .csr_we(csr_we), .csr_num(csr_num), .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .tcfg_en(tcfg_en), .tcfg_periodic(tcfg_periodic), .tcfg_initval(tcfg_initval),
        .tval(tval), .timer_int(timer_int)
    );

    csr_exc_info u_exc_info (
        .clk(clk), .reset(reset),
        .csr_we(csr_we), .csr_num(csr_num), .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .wb_ex(wb_ex), .wb_ecode(wb_ecode), .wb_esubcode(wb_esubcode),
        .wb_pc(wb_pc), .wb_vaddr(wb_vaddr),
        .hw_int(hw_int), .ipi_int(ipi_int), .timer_int(timer_int), .crmd_ie(crmd_ie),
        .ecfg_lie(ecfg_lie), .estat_is(estat_is),
        .estat_ecode(estat_ecode), .estat_esubcode(estat_esubcode),
        .era(era), .badv(badv), .eentry_va(eentry_va), .has_int(has_int)
    );

    csr_save_bank u_save_bank (
        .clk(clk),
        .csr_we(csr_we), .csr_num(csr_num), .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3)
    );

    csr_read_mux u_read_mux (
        .csr_num(csr_num),
        .crmd_plv(crmd_plv), .crmd_ie(crmd_ie), .prmd_pplv(prmd_pplv), .prmd_pie(prmd_pie),
        .ecfg_lie(ecfg_lie), .estat_is(estat_is),
        .estat_ecode(estat_ecode), .estat_esubcode(estat_esubcode),
        .era(era), .badv(badv), .eentry_va(eentry_va),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3),
        .tcfg_en(tcfg_en), .tcfg_periodic(tcfg_periodic), .tcfg_initval(tcfg_initval),
        .tval(tval),
        .csr_rvalue(csr_rvalue), .ex_entry(ex_entry)
    );

endmodule

// File: logic/csr_read_mux.sv
`include "csr_macros.svh"

module csr_read_mux (
    input  csr_pkg::csr_num_t  csr_num,
    input  csr_pkg::plv_t      crmd_plv,
    input  logic               crmd_ie,
    input  csr_pkg::plv_t      prmd_pplv,
    input  logic               prmd_pie,
    input  csr_pkg::int_vec_t  ecfg_lie,
    input  csr_pkg::int_vec_t  estat_is,
    input  csr_pkg::ecode_t    estat_ecode,
    input  csr_pkg::esubcode_t estat_esubcode,
    input  csr_pkg::csr_word_t era,
    input  csr_pkg::csr_word_t badv,
    input  logic [25:0]        eentry_va,
    input  csr_pkg::csr_word_t save0,
    input  csr_pkg::csr_word_t save1,
    input  csr_pkg::csr_word_t save2,
    input  csr_pkg::csr_word_t save3,
    input  logic               tcfg_en,
    input  logic               tcfg_periodic,
    input  logic [29:0]        tcfg_initval,
    input  csr_pkg::csr_word_t tval,
    output csr_pkg::csr_word_t csr_rvalue,
    output csr_pkg::csr_word_t ex_entry
);
    import csr_pkg::*;

    localparam int NUM_REGS = 14;

    csr_word_t           crmd_rd;
    csr_word_t           prmd_rd;
    csr_word_t           estat_rd;
    csr_word_t           eentry_rd;
    csr_word_t           tcfg_rd;
    csr_word_t           rd_word [NUM_REGS];
    logic [NUM_REGS-1:0] sel;

    always_comb begin
        crmd_rd = '0;
        crmd_rd[`CRMD_PLV] = crmd_plv;
        crmd_rd[`CRMD_IE] = crmd_ie;
        // Direct address mode is always on
        crmd_rd[`CRMD_DA] = 1'b1;
        prmd_rd = '0;
        prmd_rd[`PRMD_PPLV] = prmd_pplv;
        prmd_rd[`PRMD_PIE] = prmd_pie;
        estat_rd = {19'b0, estat_is};
        estat_rd[`ESTAT_ECODE] = estat_ecode;
        estat_rd[`ESTAT_ESUBCODE] = estat_esubcode;
        eentry_rd = '0;
        eentry_rd[`EENTRY_VA] = eentry_va;
        tcfg_rd = '0;
        tcfg_rd[`TCFG_EN] = tcfg_en;
        tcfg_rd[`TCFG_PERIOD] = tcfg_periodic;
        tcfg_rd[`TCFG_INITV] = tcfg_initval;
    end

    always_comb begin
        rd_word[0]  = crmd_rd;
        rd_word[1]  = prmd_rd;
        rd_word[2]  = {19'b0, ecfg_lie} & `ECFG_LIE_MASK;
        rd_word[3]  = estat_rd;
        rd_word[4]  = era;
        rd_word[5]  = badv;
        rd_word[6]  = eentry_rd;
        rd_word[7]  = save0;
        rd_word[8]  = save1;
        rd_word[9]  = save2;
        rd_word[10] = save3;
        rd_word[11] = tcfg_rd;
        rd_word[12] = tval;
        // TICLR is write only
        rd_word[13] = '0;
    end

    // One-hot decode of the CSR number
    always_comb begin
        sel = '0;
        sel[0]  = csr_num == `CSR_CRMD;
        sel[1]  = csr_num == `CSR_PRMD;
        sel[2]  = csr_num == `CSR_ECFG;
        sel[3]  = csr_num == `CSR_ESTAT;
        sel[4]  = csr_num == `CSR_ERA;
        sel[5]  = csr_num == `CSR_BADV;
        sel[6]  = csr_num == `CSR_EENTRY;
        sel[7]  = csr_num == `CSR_SAVE0;
        sel[8]  = csr_num == `CSR_SAVE1;
        sel[9]  = csr_num == `CSR_SAVE2;
        sel[10] = csr_num == `CSR_SAVE3;
        sel[11] = csr_num == `CSR_TCFG;
        sel[12] = csr_num == `CSR_TVAL;
        sel[13] = csr_num == `CSR_TICLR;
        csr_rvalue = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            csr_rvalue = csr_rvalue | ({32{sel[i]}} & rd_word[i]);
        end
        a_sel_onehot: assert ($onehot0(sel));
    end

    assign ex_entry = eentry_rd;

endmodule

// File: logic/csr_save_bank.sv
`include "csr_macros.svh"

module csr_save_bank (
    input  logic               clk,
    input  logic               csr_we,
    input  csr_pkg::csr_num_t  csr_num,
    input  csr_pkg::csr_word_t csr_wmask,
    input  csr_pkg::csr_word_t csr_wvalue,
    output csr_pkg::csr_word_t save0,
    output csr_pkg::csr_word_t save1,
    output csr_pkg::csr_word_t save2,
    output csr_pkg::csr_word_t save3
);
    import csr_pkg::*;

    logic [3:0] save_wr;
    csr_word_t  save_q [4];

    assign save_wr[0] = csr_we && (csr_num == `CSR_SAVE0);
    assign save_wr[1] = csr_we && (csr_num == `CSR_SAVE1);
    assign save_wr[2] = csr_we && (csr_num == `CSR_SAVE2);
    assign save_wr[3] = csr_we && (csr_num == `CSR_SAVE3);

    // Plain scratch storage for software
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (save_wr[i]) begin
                save_q[i] <= csr_merge(save_q[i], csr_wvalue, csr_wmask);
            end
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

// File: logic/csr_exc_info.sv
`include "csr_macros.svh"

module csr_exc_info (
    input  logic                clk,
    input  logic                reset,
    input  logic                csr_we,
    input  csr_pkg::csr_num_t   csr_num,
    input  csr_pkg::csr_word_t  csr_wmask,
    input  csr_pkg::csr_word_t  csr_wvalue,
    input  logic                wb_ex,
    input  csr_pkg::ecode_t     wb_ecode,
    input  csr_pkg::esubcode_t  wb_esubcode,
    input  csr_pkg::csr_word_t  wb_pc,
    input  csr_pkg::csr_word_t  wb_vaddr,
    input  logic [7:0]          hw_int,
    input  logic                ipi_int,
    input  logic                timer_int,
    input  logic                crmd_ie,
    output csr_pkg::int_vec_t   ecfg_lie,
    output csr_pkg::int_vec_t   estat_is,
    output csr_pkg::ecode_t     estat_ecode,
    output csr_pkg::esubcode_t  estat_esubcode,
    output csr_pkg::csr_word_t  era,
    output csr_pkg::csr_word_t  badv,
    output logic [25:0]         eentry_va,
    output logic                has_int
);
    import csr_pkg::*;

    logic       ecfg_wr;
    logic       estat_wr;
    logic       era_wr;
    logic       eentry_wr;
    logic       addr_err;
    logic [1:0] is_sw;
    logic [7:0] is_hw;
    logic       is_ipi;
    csr_word_t  ecfg_new;
    csr_word_t  estat_new;
    csr_word_t  era_new;
    csr_word_t  eentry_new;

    assign ecfg_wr   = csr_we && (csr_num == `CSR_ECFG);
    assign estat_wr  = csr_we && (csr_num == `CSR_ESTAT);
    assign era_wr    = csr_we && (csr_num == `CSR_ERA);
    assign eentry_wr = csr_we && (csr_num == `CSR_EENTRY);

    assign ecfg_new   = csr_merge({19'b0, ecfg_lie}, csr_wvalue, csr_wmask);
    assign estat_new  = csr_merge({30'b0, is_sw}, csr_wvalue, csr_wmask);
    assign era_new    = csr_merge(era, csr_wvalue, csr_wmask);
    assign eentry_new = csr_merge({eentry_va, 6'b0}, csr_wvalue, csr_wmask);

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            is_sw    <= 2'b00;
            is_hw    <= 8'h00;
            is_ipi   <= 1'b0;
        end else begin
            if (ecfg_wr) begin
                ecfg_lie <= ecfg_new[12:0];
            end
            if (estat_wr) begin
                is_sw <= estat_new[`ESTAT_IS10];
            end
            is_hw  <= hw_int;
            is_ipi <= ipi_int;
        end
    end

    // Bit 10 stays zero
    always_comb begin
        estat_is = '0;
        estat_is[1:0] = is_sw;
        estat_is[9:2] = is_hw;
        estat_is[`INT_TIMER_BIT] = timer_int;
        estat_is[`INT_IPI_BIT] = is_ipi;
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            era <= wb_pc;
        end else if (era_wr) begin
            era <= era_new;
        end
    end

    assign addr_err = (wb_ecode == `ECODE_ADEF) || (wb_ecode == `ECODE_ALE);

    // Fetch faults report the pc, data faults the address
    always_ff @(posedge clk) begin
        if (wb_ex && addr_err) begin
            if (wb_ecode == `ECODE_ADEF && wb_esubcode == `ESUBCODE_ADEF) begin
                badv <= wb_pc;
            end else begin
                badv <= wb_vaddr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (eentry_wr) begin
            eentry_va <= eentry_new[`EENTRY_VA];
        end
    end

    assign has_int = (|(ecfg_lie & estat_is)) && crmd_ie;

endmodule

// File: logic/csr_timer.sv
`include "csr_macros.svh"

module csr_timer (
    input  logic               clk,
    input  logic               reset,
    input  logic               csr_we,
    input  csr_pkg::csr_num_t  csr_num,
    input  csr_pkg::csr_word_t csr_wmask,
    input  csr_pkg::csr_word_t csr_wvalue,
    output logic               tcfg_en,
    output logic               tcfg_periodic,
    output logic [29:0]        tcfg_initval,
    output csr_pkg::csr_word_t tval,
    output logic               timer_int
);
    import csr_pkg::*;

    logic      tcfg_wr;
    logic      ticlr_hit;
    csr_word_t tcfg_cur;
    csr_word_t tcfg_next;
    csr_word_t timer_cnt;

    assign tcfg_wr = csr_we && (csr_num == `CSR_TCFG);

    // Clear only when both mask and value carry the CLR bit
    assign ticlr_hit = csr_we && (csr_num == `CSR_TICLR)
                    && csr_wmask[`TICLR_CLR] && csr_wvalue[`TICLR_CLR];

    always_comb begin
        tcfg_cur = '0;
        tcfg_cur[`TCFG_EN] = tcfg_en;
        tcfg_cur[`TCFG_PERIOD] = tcfg_periodic;
        tcfg_cur[`TCFG_INITV] = tcfg_initval;
    end

    assign tcfg_next = csr_merge(tcfg_cur, csr_wvalue, csr_wmask);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en <= 1'b0;
        end else if (tcfg_wr) begin
            tcfg_en <= tcfg_next[`TCFG_EN];
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_wr) begin
            tcfg_periodic <= tcfg_next[`TCFG_PERIOD];
            tcfg_initval  <= tcfg_next[`TCFG_INITV];
        end
    end

    // Countdown, idle value means stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= `TIMER_IDLE;
        end else if (tcfg_wr && tcfg_next[`TCFG_EN]) begin
            timer_cnt <= {tcfg_next[`TCFG_INITV], 2'b00};
        end else if (tcfg_en && (timer_cnt != `TIMER_IDLE)) begin
            if (timer_cnt == '0) begin
                timer_cnt <= tcfg_periodic ? {tcfg_initval, 2'b00} : `TIMER_IDLE;
            end else begin
                timer_cnt <= timer_cnt - 32'd1;
            end
        end
    end

    // Pending bit, a new expiry beats a clear
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (timer_cnt == '0) begin
            timer_int <= 1'b1;
        end else if (ticlr_hit) begin
            timer_int <= 1'b0;
        end
    end

    assign tval = timer_cnt;

    a_idle_holds: assert property (
        @(posedge clk) disable iff (reset)
        (timer_cnt == `TIMER_IDLE && !tcfg_wr) |=> (timer_cnt == `TIMER_IDLE)
    );

endmodule

// File: logic/csr_mode_ctrl.sv
`include "csr_macros.svh"

module csr_mode_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               csr_we,
    input  csr_pkg::csr_num_t  csr_num,
    input  csr_pkg::csr_word_t csr_wmask,
    input  csr_pkg::csr_word_t csr_wvalue,
    input  logic               wb_ex,
    input  logic               ertn_flush,
    output csr_pkg::plv_t      crmd_plv,
    output logic               crmd_ie,
    output csr_pkg::plv_t      prmd_pplv,
    output logic               prmd_pie
);
    import csr_pkg::*;

    logic      crmd_wr;
    logic      prmd_wr;
    csr_word_t crmd_cur;
    csr_word_t prmd_cur;
    csr_word_t crmd_new;
    csr_word_t prmd_new;

    assign crmd_wr = csr_we && (csr_num == `CSR_CRMD);
    assign prmd_wr = csr_we && (csr_num == `CSR_PRMD);

    always_comb begin
        crmd_cur = '0;
        crmd_cur[`CRMD_PLV] = crmd_plv;
        crmd_cur[`CRMD_IE] = crmd_ie;
        prmd_cur = '0;
        prmd_cur[`PRMD_PPLV] = prmd_pplv;
        prmd_cur[`PRMD_PIE] = prmd_pie;
    end

    assign crmd_new = csr_merge(crmd_cur, csr_wvalue, csr_wmask);
    assign prmd_new = csr_merge(prmd_cur, csr_wvalue, csr_wmask);

    // Exception entry wins over ertn, ertn over software writes
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b00;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= 2'b00;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (crmd_wr) begin
            crmd_plv <= crmd_new[`CRMD_PLV];
            crmd_ie  <= crmd_new[`CRMD_IE];
        end
    end

    // Saved context of the interrupted code
    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (prmd_wr) begin
            prmd_pplv <= prmd_new[`PRMD_PPLV];
            prmd_pie  <= prmd_new[`PRMD_PIE];
        end
    end

    a_ex_enters_kernel: assert property (
        @(posedge clk) disable iff (reset) wb_ex |=> (crmd_plv == 2'b00)
    );

endmodule

// File: logic/csr_pkg.sv
package csr_pkg;

    // Register and data word
    typedef logic [31:0] csr_word_t;

    typedef logic [13:0] csr_num_t;

    typedef logic [1:0]  plv_t;

    typedef logic [5:0]  ecode_t;

    typedef logic [8:0]  esubcode_t;

    // One bit per interrupt source, ESTAT IS order
    typedef logic [12:0] int_vec_t;

    // Masked write merge, new bits where the mask is set
    function automatic csr_word_t csr_merge(
        input csr_word_t old_val,
        input csr_word_t wvalue,
        input csr_word_t wmask
    );
        return (wmask & wvalue) | (~wmask & old_val);
    endfunction

endpackage

// File: include/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// CSR numbers
`define CSR_CRMD            14'h0000
`define CSR_PRMD            14'h0001
`define CSR_ECFG            14'h0004
`define CSR_ESTAT           14'h0005
`define CSR_ERA             14'h0006
`define CSR_BADV            14'h0007
`define CSR_EENTRY          14'h000c
`define CSR_SAVE0           14'h0030
`define CSR_SAVE1           14'h0031
`define CSR_SAVE2           14'h0032
`define CSR_SAVE3           14'h0033
`define CSR_TCFG            14'h0041
`define CSR_TVAL            14'h0042
`define CSR_TICLR           14'h0044

// Field positions
`define CRMD_PLV            1:0
`define CRMD_IE             2
`define CRMD_DA             3
`define PRMD_PPLV           1:0
`define PRMD_PIE            2
`define ESTAT_IS10          1:0
`define ESTAT_ECODE         21:16
`define ESTAT_ESUBCODE      30:22
`define EENTRY_VA           31:6
`define TCFG_EN             0
`define TCFG_PERIOD         1
`define TCFG_INITV          31:2
`define TICLR_CLR           0

// Exception codes
`define ECODE_ADEF          6'h08
`define ECODE_ALE           6'h09
`define ESUBCODE_ADEF       9'h000

// LIE bit 10 does not exist
`define ECFG_LIE_MASK       32'h0000_1bff
`define TIMER_IDLE          32'hffff_ffff
`define INT_TIMER_BIT       11
`define INT_IPI_BIT         12

`endif
